// ==== source/backend_cfg.svh ====
//**************************************************************************
// sizing of the integer back end
// BE_IQ_DEPTH must be a power of two, at least 2
//**************************************************************************
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// data and pc width
`define BE_XLEN 32

// entries per issue FIFO
`define BE_IQ_DEPTH 4

// reorder buffer holds 2**BE_ROB_AW entries
`define BE_ROB_AW 3

`endif

// ==== source/backend_isa_pkg.sv ====
//**************************************************************************
// micro-instruction word and its encodings
// bit 31 selects the alu or the branch view of the lower 31 bits
//**************************************************************************
package backend_isa_pkg;

	typedef union packed {
		// bit 11 is spare in the alu view
		struct packed {
			logic               cls;
			logic [2:0]         op;
			logic [4:0]         rd;
			logic [4:0]         rs1;
			logic [4:0]         rs2;
			logic               use_imm;
			logic               rsvd;
			logic signed [10:0] imm;
		} alu;
		struct packed {
			logic               cls;
			logic [2:0]         cond;
			logic [4:0]         rd;
			logic [4:0]         rs1;
			logic [4:0]         rs2;
			logic signed [12:0] off;
		} bru;
	} uop_word_u;

	localparam logic CLS_ALU = 1'b0;
	localparam logic CLS_BRU = 1'b1;

	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR  = 3'd3;
	localparam logic [2:0] ALU_XOR = 3'd4;
	localparam logic [2:0] ALU_SLL = 3'd5;
	localparam logic [2:0] ALU_SRL = 3'd6;
	localparam logic [2:0] ALU_SLT = 3'd7;

	// jal is always taken and links pc+4
	localparam logic [2:0] BR_BEQ  = 3'd0;
	localparam logic [2:0] BR_BNE  = 3'd1;
	localparam logic [2:0] BR_BLT  = 3'd2;
	localparam logic [2:0] BR_BGE  = 3'd3;
	localparam logic [2:0] BR_BLTU = 3'd4;
	localparam logic [2:0] BR_BGEU = 3'd5;
	localparam logic [2:0] BR_JAL  = 3'd6;

endpackage

// ==== source/backend_pipe_pkg.sv ====
//**************************************************************************
// pipeline widths derived from the sizing defines
// issue entry is {tag, payload, pc}, pc in the low bits
//**************************************************************************
`include "backend_cfg.svh"

package backend_pipe_pkg;

	localparam int TAG_W = `BE_ROB_AW;

	// uop word without its class bit
	localparam int PAY_W = 31;

	localparam int IQ_W = TAG_W + PAY_W + `BE_XLEN;

	localparam int IQ_PC_LSB  = 0;
	localparam int IQ_PAY_LSB = IQ_PC_LSB + `BE_XLEN;
	localparam int IQ_TAG_LSB = IQ_PAY_LSB + PAY_W;

endpackage

// ==== source/issue_fifo.sv ====
//**************************************************************************
// synchronous FIFO with a flush; DP a power of two, at least 2
// push while full and pop while empty are dropped
//**************************************************************************
`timescale 1ns/1ps

module issue_fifo #(
	parameter int DW = 32,
	parameter int DP = 4
) (
	input  logic          CLK,
	input  logic          i_arst_n,
	input  logic          i_push,
	input  logic [DW-1:0] i_data,
	input  logic          i_pop,
	input  logic          i_flush,
	output logic [DW-1:0] o_data,
	output logic          o_full,
	output logic          o_empty
);

	localparam int AW = $clog2(DP);

	logic [DW-1:0] mem [DP];
	logic [AW:0]   wr_ptr;
	logic [AW:0]   rd_ptr;
	logic          do_push;
	logic          do_pop;

	assign do_push = i_push & ~o_full;
	assign do_pop  = i_pop & ~o_empty;

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= i_data;
	end

	assign o_data  = mem[rd_ptr[AW-1:0]];
	assign o_empty = (wr_ptr == rd_ptr);
	// same slot, one lap apart
	assign o_full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);

endmodule

// ==== source/uop_dispatch.sv ====
//**************************************************************************
// in-order dispatch; one word per cycle, operands wait on the scoreboard
// one bubble after each flush while the front end refills
//**************************************************************************
`timescale 1ns/1ps
`include "backend_cfg.svh"

module uop_dispatch (
	input  logic                               CLK,
	input  logic                               i_arst_n,
	input  backend_isa_pkg::uop_word_u         i_uop,
	input  logic [`BE_XLEN-1:0]                i_uop_pc,
	input  logic                               i_uop_empty,
	input  logic                               i_alu_full,
	input  logic                               i_bru_full,
	input  logic                               i_rob_full,
	input  logic [backend_pipe_pkg::TAG_W-1:0] i_alloc_tag,
	input  logic [31:0]                        i_busy,
	input  logic                               i_flush,
	output logic                               o_uop_pop,
	output logic                               o_alu_push,
	output logic                               o_bru_push,
	output logic [backend_pipe_pkg::IQ_W-1:0]  o_iq_data,
	output logic                               o_rob_alloc,
	output logic [4:0]                         o_alloc_rd,
	output logic                               o_alloc_is_branch
);

	import backend_isa_pkg::*;
	import backend_pipe_pkg::*;

	logic        is_bru;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic        use_rs1;
	logic        use_rs2;
	logic [31:0] busy;
	logic        hazard;
	logic        room;
	logic        flush_q;

	always_comb begin
		is_bru = (i_uop.alu.cls == CLS_BRU);
		if (is_bru) begin
			rs1     = i_uop.bru.rs1;
			rs2     = i_uop.bru.rs2;
			use_rs1 = (i_uop.bru.cond != BR_JAL);
			use_rs2 = use_rs1;
			// only jal writes a register
			rd      = use_rs1 ? 5'd0 : i_uop.bru.rd;
		end else begin
			rs1     = i_uop.alu.rs1;
			rs2     = i_uop.alu.rs2;
			use_rs1 = 1'b1;
			use_rs2 = ~i_uop.alu.use_imm;
			rd      = i_uop.alu.rd;
		end
	end

	// x0 never blocks
	assign busy   = {i_busy[31:1], 1'b0};
	// raw on sources, waw on the destination
	assign hazard = (use_rs1 & busy[rs1]) | (use_rs2 & busy[rs2]) | busy[rd];
	assign room   = is_bru ? ~i_bru_full : ~i_alu_full;

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n)
			flush_q <= 1'b0;
		else
			flush_q <= i_flush;
	end

	assign o_uop_pop = ~i_uop_empty & room & ~i_rob_full & ~hazard & ~i_flush & ~flush_q;
	assign o_alu_push = o_uop_pop & ~is_bru;
	assign o_bru_push = o_uop_pop & is_bru;

	assign o_rob_alloc       = o_uop_pop;
	assign o_alloc_rd        = rd;
	assign o_alloc_is_branch = is_bru;

	always_comb begin
		o_iq_data = '0;
		o_iq_data[IQ_TAG_LSB +: TAG_W]    = i_alloc_tag;
		o_iq_data[IQ_PAY_LSB +: PAY_W]    = i_uop[PAY_W-1:0];
		o_iq_data[IQ_PC_LSB +: `BE_XLEN] = i_uop_pc;
	end

endmodule

// ==== source/int_execute.sv ====
//**************************************************************************
// alu and branch unit behind their issue FIFOs, one cycle each
// heads pop whenever present; results are not written back under flush
//**************************************************************************
`timescale 1ns/1ps
`include "backend_cfg.svh"

module int_execute (
	input  logic                               CLK,
	input  logic                               i_arst_n,
	input  logic                               i_alu_push,
	input  logic                               i_bru_push,
	input  logic [backend_pipe_pkg::IQ_W-1:0]  i_iq_data,
	input  logic [`BE_XLEN-1:0]                i_rdata_a,
	input  logic [`BE_XLEN-1:0]                i_rdata_b,
	input  logic [`BE_XLEN-1:0]                i_rdata_c,
	input  logic [`BE_XLEN-1:0]                i_rdata_d,
	input  logic                               i_flush,
	output logic                               o_alu_full,
	output logic                               o_bru_full,
	output logic [4:0]                         o_rd_addr_a,
	output logic [4:0]                         o_rd_addr_b,
	output logic [4:0]                         o_rd_addr_c,
	output logic [4:0]                         o_rd_addr_d,
	output logic                               o_alu_wb_valid,
	output logic [backend_pipe_pkg::TAG_W-1:0] o_alu_wb_tag,
	output logic [`BE_XLEN-1:0]                o_alu_wb_data,
	output logic                               o_bru_wb_valid,
	output logic [backend_pipe_pkg::TAG_W-1:0] o_bru_wb_tag,
	output logic [`BE_XLEN-1:0]                o_bru_wb_data,
	output logic                               o_bru_taken,
	output logic [`BE_XLEN-1:0]                o_bru_target
);

	import backend_isa_pkg::*;
	import backend_pipe_pkg::*;

	logic [IQ_W-1:0]     alu_head;
	logic [IQ_W-1:0]     bru_head;
	logic                alu_empty;
	logic                bru_empty;
	uop_word_u           alu_uop;
	uop_word_u           bru_uop;
	logic [`BE_XLEN-1:0] op_b;
	logic [`BE_XLEN-1:0] alu_res;
	logic [`BE_XLEN-1:0] bru_pc;
	logic [`BE_XLEN-1:0] bru_off;
	logic                bru_take;

	issue_fifo #(.DW(IQ_W), .DP(`BE_IQ_DEPTH)) u_alu_fifo (
		.CLK      (CLK),
		.i_arst_n (i_arst_n),
		.i_push   (i_alu_push),
		.i_data   (i_iq_data),
		.i_pop    (~alu_empty),
		.i_flush  (i_flush),
		.o_data   (alu_head),
		.o_full   (o_alu_full),
		.o_empty  (alu_empty)
	);

	issue_fifo #(.DW(IQ_W), .DP(`BE_IQ_DEPTH)) u_bru_fifo (
		.CLK      (CLK),
		.i_arst_n (i_arst_n),
		.i_push   (i_bru_push),
		.i_data   (i_iq_data),
		.i_pop    (~bru_empty),
		.i_flush  (i_flush),
		.o_data   (bru_head),
		.o_full   (o_bru_full),
		.o_empty  (bru_empty)
	);

	// class bit is implied by the queue
	assign alu_uop = {CLS_ALU, alu_head[IQ_PAY_LSB +: PAY_W]};
	assign bru_uop = {CLS_BRU, bru_head[IQ_PAY_LSB +: PAY_W]};

	assign o_rd_addr_a = alu_uop.alu.rs1;
	assign o_rd_addr_b = alu_uop.alu.rs2;
	assign o_rd_addr_c = bru_uop.bru.rs1;
	assign o_rd_addr_d = bru_uop.bru.rs2;

	assign op_b = alu_uop.alu.use_imm ?
		{{(`BE_XLEN-11){alu_uop.alu.imm[10]}}, alu_uop.alu.imm} : i_rdata_b;

	always_comb begin
		case (alu_uop.alu.op)
			ALU_ADD: alu_res = i_rdata_a + op_b;
			ALU_SUB: alu_res = i_rdata_a - op_b;
			ALU_AND: alu_res = i_rdata_a & op_b;
			ALU_OR:  alu_res = i_rdata_a | op_b;
			ALU_XOR: alu_res = i_rdata_a ^ op_b;
			ALU_SLL: alu_res = i_rdata_a << op_b[4:0];
			ALU_SRL: alu_res = i_rdata_a >> op_b[4:0];
			ALU_SLT: alu_res = {{(`BE_XLEN-1){1'b0}}, $signed(i_rdata_a) < $signed(op_b)};
			default: alu_res = '0;
		endcase
	end

	assign bru_pc  = bru_head[IQ_PC_LSB +: `BE_XLEN];
	assign bru_off = {{(`BE_XLEN-13){bru_uop.bru.off[12]}}, bru_uop.bru.off};

	always_comb begin
		case (bru_uop.bru.cond)
			BR_BEQ:  bru_take = (i_rdata_c == i_rdata_d);
			BR_BNE:  bru_take = (i_rdata_c != i_rdata_d);
			BR_BLT:  bru_take = ($signed(i_rdata_c) < $signed(i_rdata_d));
			BR_BGE:  bru_take = ($signed(i_rdata_c) >= $signed(i_rdata_d));
			BR_BLTU: bru_take = (i_rdata_c < i_rdata_d);
			BR_BGEU: bru_take = (i_rdata_c >= i_rdata_d);
			BR_JAL:  bru_take = 1'b1;
			default: bru_take = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_alu_wb_valid <= 1'b0;
			o_bru_wb_valid <= 1'b0;
		end else begin
			o_alu_wb_valid <= ~alu_empty & ~i_flush;
			o_bru_wb_valid <= ~bru_empty & ~i_flush;
		end
	end

	always_ff @(posedge CLK) begin
		o_alu_wb_tag  <= alu_head[IQ_TAG_LSB +: TAG_W];
		o_alu_wb_data <= alu_res;
		o_bru_wb_tag  <= bru_head[IQ_TAG_LSB +: TAG_W];
		o_bru_wb_data <= bru_pc + `BE_XLEN'd4;
		o_bru_taken   <= bru_take;
		o_bru_target  <= bru_pc + bru_off;
	end

endmodule

// ==== source/reg_commit.sv ====
//**************************************************************************
// reorder buffer, register file and scoreboard; retires one per cycle
// a retiring taken branch flushes everything younger than itself
//**************************************************************************
`timescale 1ns/1ps
`include "backend_cfg.svh"

module reg_commit (
	input  logic                               CLK,
	input  logic                               i_arst_n,
	input  logic                               i_rob_alloc,
	input  logic [4:0]                         i_alloc_rd,
	input  logic                               i_alloc_is_branch,
	input  logic [4:0]                         i_rd_addr_a,
	input  logic [4:0]                         i_rd_addr_b,
	input  logic [4:0]                         i_rd_addr_c,
	input  logic [4:0]                         i_rd_addr_d,
	input  logic                               i_alu_wb_valid,
	input  logic [backend_pipe_pkg::TAG_W-1:0] i_alu_wb_tag,
	input  logic [`BE_XLEN-1:0]                i_alu_wb_data,
	input  logic                               i_bru_wb_valid,
	input  logic [backend_pipe_pkg::TAG_W-1:0] i_bru_wb_tag,
	input  logic [`BE_XLEN-1:0]                i_bru_wb_data,
	input  logic                               i_bru_taken,
	input  logic [`BE_XLEN-1:0]                i_bru_target,
	output logic                               o_rob_full,
	output logic [backend_pipe_pkg::TAG_W-1:0] o_alloc_tag,
	output logic [31:0]                        o_busy,
	output logic [`BE_XLEN-1:0]                o_rdata_a,
	output logic [`BE_XLEN-1:0]                o_rdata_b,
	output logic [`BE_XLEN-1:0]                o_rdata_c,
	output logic [`BE_XLEN-1:0]                o_rdata_d,
	output logic                               o_commit_valid,
	output logic [4:0]                         o_commit_rd,
	output logic [`BE_XLEN-1:0]                o_commit_data,
	output logic                               o_flush,
	output logic [`BE_XLEN-1:0]                o_redirect_pc
);

	import backend_pipe_pkg::*;

	localparam int DEPTH = 1 << TAG_W;

	logic [TAG_W:0]      head;
	logic [TAG_W:0]      tail;
	logic [TAG_W-1:0]    head_idx;
	logic [DEPTH-1:0]    done;
	logic [DEPTH-1:0]    rob_br;
	logic [DEPTH-1:0]    rob_taken;
	logic [4:0]          rob_rd [DEPTH];
	logic [`BE_XLEN-1:0] rob_res [DEPTH];
	logic [`BE_XLEN-1:0] rob_tgt [DEPTH];
	logic [`BE_XLEN-1:0] regs [32];

	assign head_idx    = head[TAG_W-1:0];
	assign o_alloc_tag = tail[TAG_W-1:0];
	assign o_rob_full  = (head[TAG_W-1:0] == tail[TAG_W-1:0]) && (head[TAG_W] != tail[TAG_W]);

	assign o_commit_valid = (head != tail) & done[head_idx];
	assign o_commit_rd    = rob_rd[head_idx];
	// x0 retires as zero
	assign o_commit_data  = (o_commit_rd == 5'd0) ? '0 : rob_res[head_idx];
	assign o_flush        = o_commit_valid & rob_br[head_idx] & rob_taken[head_idx];
	assign o_redirect_pc  = rob_tgt[head_idx];

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			head <= '0;
			tail <= '0;
			done <= '0;
		end else if (o_flush) begin
			head <= '0;
			tail <= '0;
			done <= '0;
		end else begin
			if (i_rob_alloc)
				tail <= tail + 1'b1;
			if (i_alu_wb_valid)
				done[i_alu_wb_tag] <= 1'b1;
			if (i_bru_wb_valid)
				done[i_bru_wb_tag] <= 1'b1;
			if (o_commit_valid) begin
				head           <= head + 1'b1;
				done[head_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (i_rob_alloc) begin
			rob_rd[o_alloc_tag] <= i_alloc_rd;
			rob_br[o_alloc_tag] <= i_alloc_is_branch;
		end
		if (i_alu_wb_valid)
			rob_res[i_alu_wb_tag] <= i_alu_wb_data;
		if (i_bru_wb_valid) begin
			rob_res[i_bru_wb_tag]   <= i_bru_wb_data;
			rob_taken[i_bru_wb_tag] <= i_bru_taken;
			rob_tgt[i_bru_wb_tag]   <= i_bru_target;
		end
	end

	// the retiring branch itself still writes its link
	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (o_commit_valid && o_commit_rd != 5'd0) begin
			regs[o_commit_rd] <= o_commit_data;
		end
	end

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_busy <= '0;
		end else if (o_flush) begin
			o_busy <= '0;
		end else begin
			if (o_commit_valid)
				o_busy[o_commit_rd] <= 1'b0;
			if (i_rob_alloc && i_alloc_rd != 5'd0)
				o_busy[i_alloc_rd] <= 1'b1;
		end
	end

	assign o_rdata_a = regs[i_rd_addr_a];
	assign o_rdata_b = regs[i_rd_addr_b];
	assign o_rdata_c = regs[i_rd_addr_c];
	assign o_rdata_d = regs[i_rd_addr_d];

endmodule

// ==== source/back_end.sv ====
//**************************************************************************
// integer back end: dispatch, execute and commit
// front end is assumed to predict every branch not taken
//**************************************************************************
`timescale 1ns/1ps
`include "backend_cfg.svh"

module back_end (
	input  logic                       CLK,
	input  logic                       i_arst_n,
	input  backend_isa_pkg::uop_word_u i_uop,
	input  logic [`BE_XLEN-1:0]        i_uop_pc,
	input  logic                       i_uop_empty,
	output logic                       o_uop_pop,
	output logic                       o_commit_valid,
	output logic [4:0]                 o_commit_rd,
	output logic [`BE_XLEN-1:0]        o_commit_data,
	output logic                       o_flush,
	output logic [`BE_XLEN-1:0]        o_redirect_pc
);

	import backend_pipe_pkg::*;

	logic                alu_push;
	logic                bru_push;
	logic [IQ_W-1:0]     iq_data;
	logic                alu_full;
	logic                bru_full;
	logic                rob_alloc;
	logic [4:0]          alloc_rd;
	logic                alloc_is_branch;
	logic                rob_full;
	logic [TAG_W-1:0]    alloc_tag;
	logic [31:0]         busy;
	logic [4:0]          rd_addr_a;
	logic [4:0]          rd_addr_b;
	logic [4:0]          rd_addr_c;
	logic [4:0]          rd_addr_d;
	logic [`BE_XLEN-1:0] rdata_a;
	logic [`BE_XLEN-1:0] rdata_b;
	logic [`BE_XLEN-1:0] rdata_c;
	logic [`BE_XLEN-1:0] rdata_d;
	logic                alu_wb_valid;
	logic [TAG_W-1:0]    alu_wb_tag;
	logic [`BE_XLEN-1:0] alu_wb_data;
	logic                bru_wb_valid;
	logic [TAG_W-1:0]    bru_wb_tag;
	logic [`BE_XLEN-1:0] bru_wb_data;
	logic                bru_taken;
	logic [`BE_XLEN-1:0] bru_target;

	uop_dispatch u_dispatch (
		.CLK               (CLK),
		.i_arst_n          (i_arst_n),
		.i_uop             (i_uop),
		.i_uop_pc          (i_uop_pc),
		.i_uop_empty       (i_uop_empty),
		.i_alu_full        (alu_full),
		.i_bru_full        (bru_full),
		.i_rob_full        (rob_full),
		.i_alloc_tag       (alloc_tag),
		.i_busy            (busy),
		.i_flush           (o_flush),
		.o_uop_pop         (o_uop_pop),
		.o_alu_push        (alu_push),
		.o_bru_push        (bru_push),
		.o_iq_data         (iq_data),
		.o_rob_alloc       (rob_alloc),
		.o_alloc_rd        (alloc_rd),
		.o_alloc_is_branch (alloc_is_branch)
	);

	int_execute u_execute (
		.CLK            (CLK),
		.i_arst_n       (i_arst_n),
		.i_alu_push     (alu_push),
		.i_bru_push     (bru_push),
		.i_iq_data      (iq_data),
		.i_rdata_a      (rdata_a),
		.i_rdata_b      (rdata_b),
		.i_rdata_c      (rdata_c),
		.i_rdata_d      (rdata_d),
		.i_flush        (o_flush),
		.o_alu_full     (alu_full),
		.o_bru_full     (bru_full),
		.o_rd_addr_a    (rd_addr_a),
		.o_rd_addr_b    (rd_addr_b),
		.o_rd_addr_c    (rd_addr_c),
		.o_rd_addr_d    (rd_addr_d),
		.o_alu_wb_valid (alu_wb_valid),
		.o_alu_wb_tag   (alu_wb_tag),
		.o_alu_wb_data  (alu_wb_data),
		.o_bru_wb_valid (bru_wb_valid),
		.o_bru_wb_tag   (bru_wb_tag),
		.o_bru_wb_data  (bru_wb_data),
		.o_bru_taken    (bru_taken),
		.o_bru_target   (bru_target)
	);

	reg_commit u_commit (
		.CLK               (CLK),
		.i_arst_n          (i_arst_n),
		.i_rob_alloc       (rob_alloc),
		.i_alloc_rd        (alloc_rd),
		.i_alloc_is_branch (alloc_is_branch),
		.i_rd_addr_a       (rd_addr_a),
		.i_rd_addr_b       (rd_addr_b),
		.i_rd_addr_c       (rd_addr_c),
		.i_rd_addr_d       (rd_addr_d),
		.i_alu_wb_valid    (alu_wb_valid),
		.i_alu_wb_tag      (alu_wb_tag),
		.i_alu_wb_data     (alu_wb_data),
		.i_bru_wb_valid    (bru_wb_valid),
		.i_bru_wb_tag      (bru_wb_tag),
		.i_bru_wb_data     (bru_wb_data),
		.i_bru_taken       (bru_taken),
		.i_bru_target      (bru_target),
		.o_rob_full        (rob_full),
		.o_alloc_tag       (alloc_tag),
		.o_busy            (busy),
		.o_rdata_a         (rdata_a),
		.o_rdata_b         (rdata_b),
		.o_rdata_c         (rdata_c),
		.o_rdata_d         (rdata_d),
		.o_commit_valid    (o_commit_valid),
		.o_commit_rd       (o_commit_rd),
		.o_commit_data     (o_commit_data),
		.o_flush           (o_flush),
		.o_redirect_pc     (o_redirect_pc)
	);

endmodule

// ==== tb/back_end_props.sv ====
//**************************************************************************
// output properties of back_end, sampled on the rising clock
// all of them are off while reset is low
//**************************************************************************
`timescale 1ns/1ps
`include "backend_cfg.svh"

module back_end_props (
	input logic                CLK,
	input logic                i_arst_n,
	input logic                i_uop_empty,
	input logic                o_uop_pop,
	input logic                o_commit_valid,
	input logic [4:0]          o_commit_rd,
	input logic [`BE_XLEN-1:0] o_commit_data,
	input logic                o_flush
);

	int flush_fails = 0;
	int pop_fails   = 0;
	int x0_fails    = 0;

	// a flush only comes with a retiring taken branch
	assert property (@(posedge CLK) disable iff (!i_arst_n) o_flush |-> o_commit_valid)
	else begin
		flush_fails++;
		$error("flush raised without a retiring instruction");
	end

	assert property (@(posedge CLK) disable iff (!i_arst_n) i_uop_empty |-> !o_uop_pop)
	else begin
		pop_fails++;
		$error("pop while the front-end queue is empty");
	end

	assert property (@(posedge CLK) disable iff (!i_arst_n)
		(o_commit_valid && o_commit_rd == 5'd0) |-> (o_commit_data == '0))
	else begin
		x0_fails++;
		$error("retire to x0 with nonzero data");
	end

endmodule

// ==== tb/back_end_tb.sv ====
//**************************************************************************
// directed and random tests of back_end against a sequential ISA model
// generated branches only jump forward, so every program runs to its end
//**************************************************************************
`timescale 1ns/1ps

module back_end_tb;

	import backend_isa_pkg::*;

	logic        CLK;
	logic        i_arst_n;
	uop_word_u   i_uop;
	logic [31:0] i_uop_pc;
	logic        i_uop_empty;
	logic        o_uop_pop;
	logic        o_commit_valid;
	logic [4:0]  o_commit_rd;
	logic [31:0] o_commit_data;
	logic        o_flush;
	logic [31:0] o_redirect_pc;

	logic [31:0] prog [0:255];
	int          prog_len;
	logic [31:0] mreg [0:31];
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_data [$];
	logic        exp_flush [$];
	logic [31:0] exp_tgt [$];

	back_end u_dut (
		.CLK            (CLK),
		.i_arst_n       (i_arst_n),
		.i_uop          (i_uop),
		.i_uop_pc       (i_uop_pc),
		.i_uop_empty    (i_uop_empty),
		.o_uop_pop      (o_uop_pop),
		.o_commit_valid (o_commit_valid),
		.o_commit_rd    (o_commit_rd),
		.o_commit_data  (o_commit_data),
		.o_flush        (o_flush),
		.o_redirect_pc  (o_redirect_pc)
	);

	bind back_end back_end_props u_props (
		.CLK            (CLK),
		.i_arst_n       (i_arst_n),
		.i_uop_empty    (i_uop_empty),
		.o_uop_pop      (o_uop_pop),
		.o_commit_valid (o_commit_valid),
		.o_commit_rd    (o_commit_rd),
		.o_commit_data  (o_commit_data),
		.o_flush        (o_flush)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic fail_value(input string test, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		$display("Fail %s: %s expected %h actual %h", test, what, exp, act);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic fail_text(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	function automatic int prop_failures();
		return u_dut.u_props.flush_fails + u_dut.u_props.pop_fails + u_dut.u_props.x0_fails;
	endfunction

	function automatic logic [31:0] enc_alu(input logic [2:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic use_imm, input int imm);
		return {1'b0, op, rd, rs1, rs2, use_imm, 1'b0, imm[10:0]};
	endfunction

	function automatic logic [31:0] enc_br(input logic [2:0] cond, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input int off);
		return {1'b1, cond, rd, rs1, rs2, off[12:0]};
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[prog_len[7:0]] = w;
		prog_len++;
	endtask

	// sequential execution, one expected retire per executed word
	task automatic model_program();
		logic [31:0] w;
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] tgt;
		logic [4:0]  rd;
		logic        take;
		pc = '0;
		while (int'(pc >> 2) < prog_len) begin
			w    = prog[pc[9:2]];
			a    = mreg[w[22:18]];
			b    = mreg[w[17:13]];
			take = 1'b0;
			tgt  = pc + {{19{w[12]}}, w[12:0]};
			rd   = w[27:23];
			res  = pc + 32'd4;
			if (!w[31]) begin
				if (w[12])
					b = {{21{w[10]}}, w[10:0]};
				case (w[30:28])
					ALU_ADD: res = a + b;
					ALU_SUB: res = a - b;
					ALU_AND: res = a & b;
					ALU_OR:  res = a | b;
					ALU_XOR: res = a ^ b;
					ALU_SLL: res = a << b[4:0];
					ALU_SRL: res = a >> b[4:0];
					default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				endcase
			end else begin
				case (w[30:28])
					BR_BEQ:  take = (a == b);
					BR_BNE:  take = (a != b);
					BR_BLT:  take = ($signed(a) < $signed(b));
					BR_BGE:  take = ($signed(a) >= $signed(b));
					BR_BLTU: take = (a < b);
					BR_BGEU: take = (a >= b);
					default: take = 1'b1;
				endcase
				// conditional branches have no destination
				if (w[30:28] != BR_JAL)
					rd = 5'd0;
			end
			if (rd == 5'd0)
				res = '0;
			else
				mreg[rd] = res;
			exp_rd.push_back(rd);
			exp_data.push_back(res);
			exp_flush.push_back(take);
			exp_tgt.push_back(tgt);
			pc = take ? tgt : pc + 32'd4;
		end
	endtask

	// front-end queue model
	task automatic present(input logic [31:0] pc, input bit gaps);
		logic in_range;
		in_range    = int'(pc >> 2) < prog_len;
		i_uop_pc    = pc;
		i_uop       = in_range ? prog[pc[9:2]] : '0;
		i_uop_empty = !in_range || (gaps && ($urandom % 4 == 0));
	endtask

	task automatic run_program(input string test, input bit gaps);
		logic [31:0] pc;
		logic [31:0] redir;
		logic        pop;
		logic        flush;
		int          cycles;
		int          limit;
		model_program();
		pc     = '0;
		cycles = 0;
		limit  = 40 * prog_len + 200;
		present(pc, gaps);
		while (exp_rd.size() > 0) begin
			@(negedge CLK);
			cycles++;
			if (cycles > limit)
				fail_text($sformatf("%s: timed out with %0d retires missing", test, exp_rd.size()));
			assert (prop_failures() == 0)
				else fail_text($sformatf("%s: a bound property failed", test));
			if (o_commit_valid) begin
				assert (o_commit_rd == exp_rd[0])
					else fail_value(test, "commit rd", 32'(exp_rd[0]), 32'(o_commit_rd));
				assert (o_commit_data == exp_data[0])
					else fail_value(test, "commit data", exp_data[0], o_commit_data);
				assert (o_flush == exp_flush[0])
					else fail_value(test, "flush", 32'(exp_flush[0]), 32'(o_flush));
				if (exp_flush[0]) begin
					assert (o_redirect_pc == exp_tgt[0])
						else fail_value(test, "redirect pc", exp_tgt[0], o_redirect_pc);
				end
				void'(exp_rd.pop_front());
				void'(exp_data.pop_front());
				void'(exp_flush.pop_front());
				void'(exp_tgt.pop_front());
			end
			pop   = o_uop_pop;
			flush = o_flush;
			redir = o_redirect_pc;
			@(posedge CLK);
			#1;
			if (flush)
				pc = redir;
			else if (pop)
				pc = pc + 32'd4;
			present(pc, gaps);
		end
		i_uop_empty = 1'b1;
		$display("%s done in %0d cycles", test, cycles);
	endtask

	task automatic apply_reset();
		i_arst_n    = 1'b1;
		i_uop       = '0;
		i_uop_pc    = '0;
		i_uop_empty = 1'b1;
		prog_len    = 0;
		for (int r = 0; r < 32; r++)
			mreg[r] = '0;
		#1;
		i_arst_n = 1'b0;
		repeat (4) @(posedge CLK);
		#1;
		i_arst_n = 1'b1;
		@(negedge CLK);
		assert (!o_uop_pop && !o_commit_valid && !o_flush)
			else fail_text("pop, commit or flush is high right after reset");
		@(posedge CLK);
		#1;
	endtask

	task automatic test_alu_ops();
		int k;
		prog_len = 0;
		emit(enc_alu(ALU_ADD, 1, 0, 0, 1'b1, -300));
		emit(enc_alu(ALU_ADD, 2, 0, 0, 1'b1, 1000));
		for (k = 0; k < 8; k++) begin
			emit(enc_alu(3'(k), 5'(3 + k), 1, 2, 1'b0, 0));
			emit(enc_alu(3'(k), 5'(11 + k), 1, 0, 1'b1, 7 - 2 * k));
		end
		run_program("alu_ops", 1'b0);
	endtask

	task automatic test_dep_chain();
		prog_len = 0;
		emit(enc_alu(ALU_ADD, 5, 0, 0, 1'b1, 5));
		emit(enc_alu(ALU_ADD, 5, 5, 5, 1'b0, 0));
		emit(enc_alu(ALU_SUB, 6, 5, 0, 1'b1, 3));
		emit(enc_alu(ALU_SLL, 5, 6, 5, 1'b0, 0));
		emit(enc_alu(ALU_XOR, 6, 6, 5, 1'b0, 0));
		emit(enc_alu(ALU_SRL, 7, 6, 0, 1'b1, 2));
		emit(enc_alu(ALU_SLT, 5, 7, 6, 1'b0, 0));
		emit(enc_alu(ALU_OR, 6, 5, 7, 1'b0, 0));
		run_program("dep_chain", 1'b0);
	endtask

	// x1 = 5 and x2 = -3 make every condition false
	task automatic test_branch_not_taken();
		prog_len = 0;
		emit(enc_alu(ALU_ADD, 1, 0, 0, 1'b1, 5));
		emit(enc_alu(ALU_ADD, 2, 0, 0, 1'b1, -3));
		emit(enc_br(BR_BEQ, 9, 1, 2, 8));
		emit(enc_alu(ALU_ADD, 20, 9, 0, 1'b1, 1));
		emit(enc_br(BR_BNE, 9, 1, 1, 8));
		emit(enc_alu(ALU_ADD, 21, 20, 0, 1'b1, 1));
		emit(enc_br(BR_BLT, 9, 1, 2, 8));
		emit(enc_alu(ALU_ADD, 22, 21, 0, 1'b1, 1));
		emit(enc_br(BR_BGE, 9, 2, 1, 8));
		emit(enc_alu(ALU_ADD, 23, 22, 0, 1'b1, 1));
		emit(enc_br(BR_BLTU, 9, 2, 1, 8));
		emit(enc_alu(ALU_ADD, 24, 23, 0, 1'b1, 1));
		emit(enc_br(BR_BGEU, 9, 1, 2, 8));
		emit(enc_alu(ALU_ADD, 25, 24, 9, 1'b0, 0));
		run_program("branch_not_taken", 1'b0);
	endtask

	task automatic test_branch_taken();
		prog_len = 0;
		emit(enc_alu(ALU_ADD, 1, 0, 0, 1'b1, 5));
		emit(enc_alu(ALU_ADD, 2, 0, 0, 1'b1, 5));
		emit(enc_alu(ALU_ADD, 3, 0, 0, 1'b1, -1));
		emit(enc_br(BR_BEQ, 0, 1, 2, 12));
		emit(enc_alu(ALU_ADD, 4, 0, 0, 1'b1, 111));
		emit(enc_alu(ALU_ADD, 5, 0, 0, 1'b1, 222));
		emit(enc_alu(ALU_ADD, 6, 4, 5, 1'b0, 0));
		emit(enc_br(BR_BLTU, 0, 1, 3, 8));
		emit(enc_alu(ALU_ADD, 7, 0, 0, 1'b1, 333));
		emit(enc_br(BR_BGE, 0, 1, 3, 8));
		emit(enc_alu(ALU_ADD, 8, 0, 0, 1'b1, 444));
		emit(enc_alu(ALU_ADD, 9, 7, 8, 1'b0, 0));
		run_program("branch_taken", 1'b0);
	endtask

	task automatic test_jal_x0();
		prog_len = 0;
		emit(enc_alu(ALU_ADD, 1, 0, 0, 1'b1, 9));
		emit(enc_br(BR_JAL, 10, 0, 0, 8));
		emit(enc_alu(ALU_ADD, 11, 0, 0, 1'b1, 55));
		emit(enc_alu(ALU_ADD, 12, 10, 0, 1'b1, 0));
		emit(enc_alu(ALU_ADD, 0, 1, 0, 1'b1, 100));
		emit(enc_alu(ALU_OR, 13, 0, 1, 1'b0, 0));
		emit(enc_br(BR_JAL, 0, 0, 0, 4));
		emit(enc_alu(ALU_ADD, 14, 0, 0, 1'b1, 1));
		run_program("jal_x0", 1'b0);
	endtask

	task automatic test_random_mix();
		int n;
		int off;
		prog_len = 0;
		for (n = 0; n < 200; n++) begin
			if ($urandom % 10 < 7) begin
				emit(enc_alu(3'($urandom % 8), 5'($urandom % 8), 5'($urandom % 8),
					5'($urandom % 8), 1'($urandom % 2), int'($urandom % 2048)));
			end else begin
				off = 4 * (1 + int'($urandom % 4));
				if (4 * n + off > 800)
					off = 800 - 4 * n;
				emit(enc_br(3'($urandom % 7), 5'($urandom % 8), 5'($urandom % 8),
					5'($urandom % 8), off));
			end
		end
		run_program("random_mix", 1'b1);
	endtask

	initial begin
		void'($urandom(32'h80b4));
		apply_reset();
		test_alu_ops();
		test_dep_chain();
		test_branch_not_taken();
		test_branch_taken();
		test_jal_x0();
		test_random_mix();
		if (prop_failures() == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			fail_text("a bound property failed near the end of the run");
		end
	end

endmodule

// ==== list.f ====
+incdir+source
source/backend_isa_pkg.sv
source/backend_pipe_pkg.sv
source/issue_fifo.sv
source/uop_dispatch.sv
source/int_execute.sv
source/reg_commit.sv
source/back_end.sv
tb/back_end_props.sv
tb/back_end_tb.sv

// ==== Makefile ====
# Verilator build and run of the back end testbench

VERILATOR ?= verilator
TOP       ?= back_end_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FILELIST  := list.f
SOURCES   := $(wildcard source/*.sv source/*.svh tb/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
